/* Bender.yml */
package:
  name: channel_core

sources:
  - files:
      - hdl/wfd_pkg.sv
      - hdl/sync_fifo.sv
      - hdl/fill_acquisition.sv
      - hdl/burst_mem_arbiter.sv
      - hdl/fill_readout.sv
      - hdl/channel_core.sv
  - target: test
    files:
      - dv/channel_core_tb.sv

/* compile.f */
hdl/wfd_pkg.sv
hdl/sync_fifo.sv
hdl/fill_acquisition.sv
hdl/burst_mem_arbiter.sv
hdl/fill_readout.sv
hdl/channel_core.sv
dv/channel_core_tb.sv

/* dv/channel_core_tb.sv */
`timescale 1ns/1ns

module channel_core_tb;
	import wfd_pkg::*;

	localparam int MUON_BURSTS = 3;
	localparam int LASER_BURSTS = 5;
	localparam int PED_BURSTS = 2;
	localparam int WRAP_BURSTS = 40;     // six of these run past the memory end
	localparam int MEM_BURSTS = 256;
	localparam int TOTAL_BURSTS = 4 * MUON_BURSTS + 2 * LASER_BURSTS + 2 * PED_BURSTS +
		6 * WRAP_BURSTS;
	localparam int TOTAL_FILLS = 14;
	localparam int TOTAL_SAMPLES = TOTAL_BURSTS * SAMPLES_PER_BURST;
	localparam int TOTAL_WORDS = (TOTAL_FILLS + TOTAL_BURSTS) * WORDS_PER_BURST;
	localparam int CYCLE_LIMIT = 2 * (TOTAL_SAMPLES * 3 + TOTAL_WORDS * 2) + 1000;

	logic clk;
	logic reset;
	sample_t adc_data;
	logic adc_valid;
	logic acq_trig;
	fill_type_e acq_enable;
	channel_tag_t channel_tag;
	burst_count_t num_muon_bursts;
	burst_count_t num_laser_bursts;
	burst_count_t num_ped_bursts;
	fill_num_t initial_fill_num;
	logic initial_fill_num_wr;
	logic readout_pause;
	logic tx_ready;
	logic acq_done;
	fill_num_t fill_num;
	word_t tx_data;
	logic tx_valid;
	logic tx_last;

	integer seed = 32'h346f207f;     // sample data and gaps
	integer ready_seed;              // own stream for tx_ready stalls
	int errors;
	int words_checked;
	int packets_checked;
	int cycles;
	bit rand_ready;                  // stall tx_ready at random when set
	sample_t fill_samples[$];        // samples of the fill being sent
	word_t exp_words[$];
	bit exp_last[$];
	fill_header_t exp_hdrs[$];
	fill_num_t exp_fill_nums[$];     // fill_num expected at each acq_done
	fill_num_t model_fill_num;
	int model_addr;                  // next burst address of the model
	int word_pos;                    // word within the packet on the wire
	logic [BURST_W-1:0] got_hdr_bits;
	bit stall_prev;
	word_t held_data;
	logic held_last;
	bit exp_l;

	channel_core #(
		.MEM_ADDR_W(8),
		.BURST_FIFO_DEPTH(8),
		.HEADER_FIFO_DEPTH(4)
	) DUT (
		.clk(clk), .reset(reset),
		.adc_data(adc_data), .adc_valid(adc_valid),
		.acq_trig(acq_trig), .acq_enable(acq_enable),
		.channel_tag(channel_tag),
		.num_muon_bursts(num_muon_bursts),
		.num_laser_bursts(num_laser_bursts),
		.num_ped_bursts(num_ped_bursts),
		.initial_fill_num(initial_fill_num), .initial_fill_num_wr(initial_fill_num_wr),
		.readout_pause(readout_pause), .tx_ready(tx_ready),
		.acq_done(acq_done), .fill_num(fill_num),
		.tx_data(tx_data), .tx_valid(tx_valid), .tx_last(tx_last)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;   // 100 ns period
	end

	////////////////////////////////////////////////////////////
	// compare tasks
	task automatic check_word(input word_t got, input word_t exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED tx_data: got 0x%h expected 0x%h", got, exp);
		end
	endtask

	task automatic check_last(input bit got, input bit exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED tx_last: got 0x%h expected 0x%h", got, exp);
		end
	endtask

	task automatic check_header(input fill_header_t got, input fill_header_t exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED header: got 0x%h expected 0x%h", got, exp);
		end
	endtask

	task automatic check_fill_num(input fill_num_t got, input fill_num_t exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED fill_num: got 0x%h expected 0x%h", got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////
	// reference model, one packet per fill
	function automatic void build_packet(input fill_type_e ftype, input int nb,
		input channel_tag_t tag);
		fill_header_t hdr;
		burst_t b;
		hdr = '0;
		hdr.fill_num = model_fill_num;
		hdr.fill_type = ftype;
		hdr.channel_tag = tag;
		hdr.burst_count = burst_count_t'(nb);
		hdr.start_addr = 8'(model_addr);   // first address of the fill
		hdr.overrun = 1'b0;                // samples never outrun the writer here
		exp_hdrs.push_back(hdr);
		for (int i = 0; i < WORDS_PER_BURST; i++) begin
			exp_words.push_back(hdr[BURST_W-1-i*WORD_W -: WORD_W]);   // msw first
			exp_last.push_back(nb == 0 && i == WORDS_PER_BURST - 1);
		end
		for (int j = 0; j < nb; j++) begin
			b = '0;
			for (int k = 0; k < SAMPLES_PER_BURST; k++)
				b[k*SLOT_W +: SLOT_W] = SLOT_W'(fill_samples[j*SAMPLES_PER_BURST + k]);
			for (int i = 0; i < WORDS_PER_BURST; i++) begin
				exp_words.push_back(b[BURST_W-1-i*WORD_W -: WORD_W]);
				exp_last.push_back(j == nb - 1 && i == WORDS_PER_BURST - 1);
			end
		end
		model_addr = (model_addr + nb) % MEM_BURSTS;   // next fill follows on
		model_fill_num = model_fill_num + 1'b1;
		exp_fill_nums.push_back(model_fill_num);       // fill_num already advanced at done
	endfunction

	////////////////////////////////////////////////////////////
	// stimulus helpers, all on the falling edge
	task automatic run_fill(input fill_type_e ftype, input bit retrig);
		int nb;
		int gap;
		int n;
		sample_t s;
		channel_tag_t tag;
		case (ftype)
			FILL_MUON: nb = num_muon_bursts;
			FILL_LASER: nb = num_laser_bursts;
			FILL_PEDESTAL: nb = num_ped_bursts;
			default: nb = 0;
		endcase
		fill_samples.delete();
		tag = channel_tag;   // taken by the fill at its trigger edge
		@(negedge clk);
		acq_enable = ftype;
		acq_trig = 1'b1;   // rising edge, samples start next cycle
		adc_valid = 1'b0;
		@(negedge clk);
		acq_trig = 1'b0;
		for (int i = 0; i < nb * SAMPLES_PER_BURST; i++) begin
			s = sample_t'($random(seed));
			adc_data = s;
			adc_valid = 1'b1;
			fill_samples.push_back(s);
			if (retrig && i == 10) begin   // second edge inside the fill
				acq_trig = 1'b1;
				acq_enable = (ftype == FILL_LASER) ? FILL_PEDESTAL : FILL_LASER;
				channel_tag = ~tag;         // other type and tag, must not reach the header
			end
			@(negedge clk);
			adc_valid = 1'b0;
			acq_trig = 1'b0;
			gap = 1 + ($random(seed) & 1);           // one or two idle cycles
			repeat (gap) @(negedge clk);
		end
		build_packet(ftype, nb, tag);
		n = 0;
		while (exp_fill_nums.size() != 0 && n < 500) begin
			@(negedge clk);
			n++;
		end
		if (exp_fill_nums.size() != 0) begin
			errors++;
			$display("no acq_done seen for fill 0x%h", exp_fill_nums[0]);
			exp_fill_nums.delete();
		end
	endtask

	task automatic trigger_while_disabled();
		@(negedge clk);
		acq_enable = FILL_NONE;
		acq_trig = 1'b1;
		@(negedge clk);
		acq_trig = 1'b0;
		for (int i = 0; i < 16; i++) begin
			adc_data = sample_t'($random(seed));
			adc_valid = 1'b1;
			@(negedge clk);
			adc_valid = 1'b0;
			@(negedge clk);
		end
		repeat (50) @(negedge clk);   // monitors flag any word or acq_done
	endtask

	task automatic wait_drain(input int budget);
		int n;
		n = 0;
		while ((exp_words.size() != 0 || exp_fill_nums.size() != 0) && n < budget) begin
			@(negedge clk);
			n++;
		end
		if (exp_words.size() != 0 || exp_fill_nums.size() != 0) begin
			errors++;
			$display("missing %0d packet words and %0d acq_done pulses after %0d cycles",
				exp_words.size(), exp_fill_nums.size(), budget);
			exp_words.delete();
			exp_last.delete();
			exp_hdrs.delete();
			exp_fill_nums.delete();
		end
	endtask

	task automatic print_counts();
		$display("%0d words in %0d packets checked, %0d errors",
			words_checked, packets_checked, errors);
	endtask

	////////////////////////////////////////////////////////////
	// monitors
	always @(negedge clk) begin
		if (rand_ready) tx_ready = ($random(ready_seed) & 3) != 0;   // ready about 3 of 4
		else tx_ready = 1'b1;
	end

	always @(posedge clk) begin
		if (!reset && acq_done === 1'b1) begin
			if (exp_fill_nums.size() == 0) begin
				errors++;
				$display("acq_done pulsed without a fill");
			end else check_fill_num(fill_num, exp_fill_nums.pop_front());
		end
	end

	always @(posedge clk) begin
		if (!reset) begin
			if (tx_valid && readout_pause) begin
				errors++;
				$display("packet word sent while readout_pause was high");
			end
			if (stall_prev) begin             // stalled word must hold
				if (tx_valid !== 1'b1) begin
					errors++;
					$display("tx_valid dropped during a stall");
				end else begin
					check_word(tx_data, held_data);
					check_last(tx_last, held_last);
				end
			end
			if (tx_valid && tx_ready) begin
				if (exp_words.size() == 0) begin
					errors++;
					$display("word 0x%h sent with no packet expected", tx_data);
				end else begin
					exp_l = exp_last.pop_front();
					check_word(tx_data, exp_words.pop_front());
					check_last(tx_last, exp_l);
					words_checked++;
					if (word_pos < WORDS_PER_BURST)
						got_hdr_bits[BURST_W-1-word_pos*WORD_W -: WORD_W] = tx_data;
					if (word_pos == WORDS_PER_BURST - 1)
						check_header(fill_header_t'(got_hdr_bits), exp_hdrs.pop_front());
					if (exp_l) begin
						word_pos = 0;
						packets_checked++;
					end else word_pos++;
				end
			end
			stall_prev = tx_valid && !tx_ready;
			held_data = tx_data;
			held_last = tx_last;
		end
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout, run passed %0d cycles", CYCLE_LIMIT);
		print_counts();
		$display("Verification failed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// test sequence
	initial begin
		reset = 1'b1;
		adc_data = '0;
		adc_valid = 1'b0;
		acq_trig = 1'b0;
		acq_enable = FILL_NONE;
		channel_tag = 16'h5a3c;
		num_muon_bursts = MUON_BURSTS;
		num_laser_bursts = LASER_BURSTS;
		num_ped_bursts = PED_BURSTS;
		initial_fill_num = 24'h000a50;
		initial_fill_num_wr = 1'b0;
		readout_pause = 1'b0;
		tx_ready = 1'b1;
		rand_ready = 1'b0;
		ready_seed = seed ^ 32'h0f0f0f0f;
		errors = 0;
		words_checked = 0;
		packets_checked = 0;
		model_addr = 0;
		word_pos = 0;
		stall_prev = 1'b0;
		repeat (2) @(negedge clk);
		reset = 1'b0;
		if (acq_done !== 1'b0 || tx_valid !== 1'b0) begin
			errors++;
			$display("acq_done or tx_valid not low after reset");
		end
		initial_fill_num_wr = 1'b1;        // load the fill number
		@(negedge clk);
		initial_fill_num_wr = 1'b0;
		model_fill_num = initial_fill_num;
		check_fill_num(fill_num, initial_fill_num);

		run_fill(FILL_MUON, 1'b0);          // 16 word packet
		wait_drain(2000);
		channel_tag = 16'hc3a5;
		run_fill(FILL_LASER, 1'b0);
		wait_drain(2000);
		run_fill(FILL_PEDESTAL, 1'b0);
		wait_drain(2000);

		trigger_while_disabled();           // ignored trigger
		run_fill(FILL_MUON, 1'b1);          // extra edge mid fill is ignored
		wait_drain(2000);

		// fills queue up behind the pause
		rand_ready = 1'b1;
		readout_pause = 1'b1;
		run_fill(FILL_MUON, 1'b0);
		run_fill(FILL_LASER, 1'b0);
		run_fill(FILL_PEDESTAL, 1'b0);
		repeat (20) @(negedge clk);
		readout_pause = 1'b0;
		wait_drain(2000);

		// long fills run the address past 255
		num_muon_bursts = WRAP_BURSTS;
		for (int f = 0; f < 6; f++) run_fill(FILL_MUON, 1'b0);
		num_muon_bursts = MUON_BURSTS;
		run_fill(FILL_MUON, 1'b0);          // starts after the wrap
		wait_drain(2000);
		repeat (10) @(negedge clk);

		print_counts();
		if (errors == 0) $display("Verification passed");
		else $display("Verification failed");
		$finish;
	end

endmodule

/* hdl/burst_mem_arbiter.sv */
`timescale 1ns/1ns

module burst_mem_arbiter #(
	parameter int MEM_ADDR_W = 8
) (
	input  logic clk,
	input  logic reset,
	input  logic wr_req,                   // write client, four phase
	input  logic [MEM_ADDR_W-1:0] wr_addr,
	input  wfd_pkg::burst_t wr_burst,
	input  logic rd_req,                   // read client, four phase
	input  logic [MEM_ADDR_W-1:0] rd_addr,
	output logic wr_ack,
	output logic rd_ack,
	output wfd_pkg::burst_t rd_burst       // valid while rd_ack is high
);
	import wfd_pkg::*;

	localparam int MEM_DEPTH = 2 ** MEM_ADDR_W;

	typedef enum logic [1:0] {GNT_IDLE, GNT_WR, GNT_RD} grant_e;

	grant_e grant;               // ack of the granted client follows this
	burst_t mem [MEM_DEPTH];     // burst memory
	logic wr_take;
	logic rd_take;

	////////////////////////////////////////////////////////////
	// grant, writer first
	assign wr_take = (grant == GNT_IDLE) && wr_req;
	assign rd_take = (grant == GNT_IDLE) && !wr_req && rd_req; // reader waits on a write

	assign wr_ack = (grant == GNT_WR);
	assign rd_ack = (grant == GNT_RD);

	always_ff @(posedge clk) begin
		if (reset) begin
			grant <= GNT_IDLE;
		end else begin
			case (grant)
				GNT_IDLE: begin
					if (wr_take) grant <= GNT_WR;
					else if (rd_take) grant <= GNT_RD;
				end
				GNT_WR: if (!wr_req) grant <= GNT_IDLE; // ack falls after req
				GNT_RD: if (!rd_req) grant <= GNT_IDLE;
				default: grant <= GNT_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// memory array
	always_ff @(posedge clk) begin
		if (wr_take) mem[wr_addr] <= wr_burst;   // written as ack rises
	end

	always_ff @(posedge clk) begin
		if (rd_take) rd_burst <= mem[rd_addr];   // held until the next read
	end

endmodule

/* hdl/channel_core.sv */
`timescale 1ns/1ns

module channel_core #(
	parameter int MEM_ADDR_W = 8,         // 256 bursts
	parameter int BURST_FIFO_DEPTH = 8,
	parameter int HEADER_FIFO_DEPTH = 4
) (
	input  logic clk,
	input  logic reset,
	input  wfd_pkg::sample_t adc_data,
	input  logic adc_valid,
	input  logic acq_trig,
	input  wfd_pkg::fill_type_e acq_enable,
	input  wfd_pkg::channel_tag_t channel_tag,
	input  wfd_pkg::burst_count_t num_muon_bursts,
	input  wfd_pkg::burst_count_t num_laser_bursts,
	input  wfd_pkg::burst_count_t num_ped_bursts,
	input  wfd_pkg::fill_num_t initial_fill_num,
	input  logic initial_fill_num_wr,
	input  logic readout_pause,
	input  logic tx_ready,
	output logic acq_done,
	output wfd_pkg::fill_num_t fill_num,
	output wfd_pkg::word_t tx_data,
	output logic tx_valid,
	output logic tx_last
);
	import wfd_pkg::*;

	logic wr_req, wr_ack, rd_req, rd_ack;
	logic [MEM_ADDR_W-1:0] wr_addr, rd_addr;
	burst_t wr_burst, rd_burst;
	logic hdr_push, hdr_pop, hdr_full, hdr_empty;
	fill_header_t hdr_in, hdr_out;

	////////////////////////////////////////////////////////////
	// acquisition side
	fill_acquisition #(
		.MEM_ADDR_W(MEM_ADDR_W),
		.BURST_FIFO_DEPTH(BURST_FIFO_DEPTH)
	) fill_acquisition (
		.clk(clk), .reset(reset),
		.adc_data(adc_data), .adc_valid(adc_valid),        // sample stream
		.acq_trig(acq_trig), .acq_enable(acq_enable),      // fill start and type
		.channel_tag(channel_tag),
		.num_muon_bursts(num_muon_bursts),
		.num_laser_bursts(num_laser_bursts),
		.num_ped_bursts(num_ped_bursts),
		.initial_fill_num(initial_fill_num), .initial_fill_num_wr(initial_fill_num_wr),
		.wr_ack(wr_ack), .hdr_full(hdr_full),
		.acq_done(acq_done), .fill_num(fill_num),
		.wr_req(wr_req), .wr_addr(wr_addr), .wr_burst(wr_burst), // memory write client
		.hdr_push(hdr_push), .hdr_data(hdr_in)
	);

	sync_fifo #(
		.payload_t(fill_header_t),
		.DEPTH(HEADER_FIFO_DEPTH)
	) header_fifo (
		.clk(clk), .reset(reset),
		.push(hdr_push), .push_data(hdr_in),   // from acquisition
		.pop(hdr_pop), .pop_data(hdr_out),     // to readout
		.empty(hdr_empty), .full(hdr_full)
	);

	////////////////////////////////////////////////////////////
	// shared burst memory
	burst_mem_arbiter #(
		.MEM_ADDR_W(MEM_ADDR_W)
	) burst_mem_arbiter (
		.clk(clk), .reset(reset),
		.wr_req(wr_req), .wr_addr(wr_addr), .wr_burst(wr_burst),
		.rd_req(rd_req), .rd_addr(rd_addr),
		.wr_ack(wr_ack), .rd_ack(rd_ack), .rd_burst(rd_burst)
	);

	////////////////////////////////////////////////////////////
	// readout side
	fill_readout #(
		.MEM_ADDR_W(MEM_ADDR_W)
	) fill_readout (
		.clk(clk), .reset(reset),
		.hdr_empty(hdr_empty), .hdr_data(hdr_out),
		.readout_pause(readout_pause),
		.rd_ack(rd_ack), .rd_burst(rd_burst),
		.tx_ready(tx_ready),
		.hdr_pop(hdr_pop),
		.rd_req(rd_req), .rd_addr(rd_addr),                 // memory read client
		.tx_data(tx_data), .tx_valid(tx_valid), .tx_last(tx_last) // packet stream
	);

endmodule

/* hdl/fill_acquisition.sv */
`timescale 1ns/1ns

module fill_acquisition #(
	parameter int MEM_ADDR_W = 8,
	parameter int BURST_FIFO_DEPTH = 8
) (
	input  logic clk,
	input  logic reset,
	input  wfd_pkg::sample_t adc_data,
	input  logic adc_valid,                    // one sample per cycle when high
	input  logic acq_trig,                     // rising edge starts a fill
	input  wfd_pkg::fill_type_e acq_enable,    // fill type, none disables triggers
	input  wfd_pkg::channel_tag_t channel_tag,
	input  wfd_pkg::burst_count_t num_muon_bursts,
	input  wfd_pkg::burst_count_t num_laser_bursts,
	input  wfd_pkg::burst_count_t num_ped_bursts,
	input  wfd_pkg::fill_num_t initial_fill_num,
	input  logic initial_fill_num_wr,          // load strobe for the fill number
	input  logic wr_ack,
	input  logic hdr_full,
	output logic acq_done,                     // one cycle after the header push
	output wfd_pkg::fill_num_t fill_num,       // number of the current or next fill
	output logic wr_req,
	output logic [MEM_ADDR_W-1:0] wr_addr,
	output wfd_pkg::burst_t wr_burst,
	output logic hdr_push,
	output wfd_pkg::fill_header_t hdr_data
);
	import wfd_pkg::*;

	localparam int SLOT_IDX_W = $clog2(SAMPLES_PER_BURST);

	typedef enum logic [1:0] {ACQ_IDLE, ACQ_RUN, ACQ_HDR} acq_state_e;
	typedef enum logic [1:0] {WR_IDLE, WR_REQ, WR_WAIT} wr_state_e;

	acq_state_e acq_state;
	wr_state_e wr_state;
	logic trig_d;                          // for edge detect
	logic fill_start;
	fill_type_e fill_type_q;               // sampled at the trigger
	channel_tag_t tag_q;
	burst_count_t burst_sel;
	burst_count_t burst_total;             // bursts in this fill
	burst_count_t packed_cnt;              // bursts packed or dropped so far
	logic [SLOT_IDX_W-1:0] slot;           // next slot in pack_buf
	burst_t pack_buf;
	burst_t fifo_in;
	logic overrun;
	logic [MEM_ADDR_W-1:0] fill_base;      // start address of this fill
	logic [MEM_ADDR_W-1:0] next_base;
	logic sample_take;
	logic burst_done;
	logic packing_done;
	logic fifo_push;
	logic fifo_pop;
	logic fifo_empty;
	logic fifo_full;

	////////////////////////////////////////////////////////////
	// trigger and burst count select
	assign fill_start = acq_trig && !trig_d && (acq_state == ACQ_IDLE) &&
		(acq_enable != FILL_NONE);

	always_comb begin
		case (acq_enable)
			FILL_MUON: burst_sel = num_muon_bursts;
			FILL_LASER: burst_sel = num_laser_bursts;
			FILL_PEDESTAL: burst_sel = num_ped_bursts;
			default: burst_sel = '0;   // disabled
		endcase
	end

	////////////////////////////////////////////////////////////
	// sample packing
	assign packing_done = (packed_cnt == burst_total);
	assign sample_take = (acq_state == ACQ_RUN) && adc_valid && !packing_done;
	assign burst_done = sample_take && (slot == SLOT_IDX_W'(SAMPLES_PER_BURST - 1));
	assign fifo_push = burst_done && !fifo_full; // full fifo drops the burst

	always_comb begin
		fifo_in = pack_buf;
		fifo_in[(SAMPLES_PER_BURST-1)*SLOT_W +: SLOT_W] = SLOT_W'(adc_data); // last slot live
	end

	always_ff @(posedge clk) begin
		if (sample_take) pack_buf[slot*SLOT_W +: SLOT_W] <= SLOT_W'(adc_data); // zero extend
	end

	assign next_base = fill_base + burst_total[MEM_ADDR_W-1:0]; // wraps with the memory

	always_ff @(posedge clk) begin
		if (reset) begin
			acq_state <= ACQ_IDLE;
			trig_d <= 1'b0;
			fill_type_q <= FILL_NONE;
			burst_total <= '0;
			packed_cnt <= '0;
			slot <= '0;
			overrun <= 1'b0;
			fill_base <= '0;
		end else begin
			trig_d <= acq_trig;
			case (acq_state)
				ACQ_IDLE: if (fill_start) begin
					fill_type_q <= acq_enable;
					burst_total <= burst_sel;
					packed_cnt <= '0;
					slot <= '0;
					overrun <= 1'b0;
					acq_state <= ACQ_RUN;
				end
				ACQ_RUN: begin
					if (sample_take) slot <= slot + 1'b1;
					if (burst_done) begin
						packed_cnt <= packed_cnt + 1'b1;
						if (fifo_full) overrun <= 1'b1; // slot stays reserved in memory
					end
					// all bursts packed and written back
					if (packing_done && fifo_empty && wr_state == WR_IDLE) acq_state <= ACQ_HDR;
				end
				ACQ_HDR: if (!hdr_full) begin
					fill_base <= next_base;
					acq_state <= ACQ_IDLE;
				end
				default: acq_state <= ACQ_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (fill_start) tag_q <= channel_tag;
	end

	sync_fifo #(
		.payload_t(burst_t),
		.DEPTH(BURST_FIFO_DEPTH)
	) burst_fifo (
		.clk(clk),
		.reset(reset),
		.push(fifo_push),
		.push_data(fifo_in),
		.pop(fifo_pop),       // after the write is acked
		.pop_data(wr_burst),  // head is the burst being written
		.empty(fifo_empty),
		.full(fifo_full)
	);

	////////////////////////////////////////////////////////////
	// memory write client, four phase
	assign wr_req = (wr_state == WR_REQ);
	assign fifo_pop = (wr_state == WR_REQ) && wr_ack;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_state <= WR_IDLE;
			wr_addr <= '0;
		end else begin
			case (wr_state)
				WR_IDLE: if (!fifo_empty && !wr_ack) wr_state <= WR_REQ;
				WR_REQ: if (wr_ack) begin
					wr_addr <= wr_addr + 1'b1;
					wr_state <= WR_WAIT;  // drop req
				end
				WR_WAIT: if (!wr_ack) wr_state <= WR_IDLE;
				default: wr_state <= WR_IDLE;
			endcase
			if (hdr_push) wr_addr <= next_base; // skip slots of dropped bursts
		end
	end

	////////////////////////////////////////////////////////////
	// header and fill numbering
	assign hdr_push = (acq_state == ACQ_HDR) && !hdr_full;

	always_comb begin
		hdr_data = '0;
		hdr_data.fill_num = fill_num;
		hdr_data.fill_type = fill_type_q;
		hdr_data.channel_tag = tag_q;
		hdr_data.burst_count = burst_total;
		hdr_data.start_addr = HDR_ADDR_W'(fill_base);
		hdr_data.overrun = overrun;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			fill_num <= '0;
			acq_done <= 1'b0;
		end else begin
			acq_done <= hdr_push;
			if (initial_fill_num_wr) fill_num <= initial_fill_num;
			else if (hdr_push) fill_num <= fill_num + 1'b1;
		end
	end

endmodule

/* hdl/fill_readout.sv */
`timescale 1ns/1ns

module fill_readout #(
	parameter int MEM_ADDR_W = 8
) (
	input  logic clk,
	input  logic reset,
	input  logic hdr_empty,
	input  wfd_pkg::fill_header_t hdr_data,  // head of the header fifo
	input  logic readout_pause,              // hold off new packets
	input  logic rd_ack,
	input  wfd_pkg::burst_t rd_burst,
	input  logic tx_ready,
	output logic hdr_pop,
	output logic rd_req,
	output logic [MEM_ADDR_W-1:0] rd_addr,
	output wfd_pkg::word_t tx_data,
	output logic tx_valid,
	output logic tx_last                     // final word of the packet
);
	import wfd_pkg::*;

	localparam int WORD_IDX_W = $clog2(WORDS_PER_BURST);

	typedef enum logic [1:0] {RD_IDLE, RD_HDR, RD_REQ, RD_BURST} rd_state_e;

	rd_state_e state;
	fill_header_t hdr_q;                 // header of the packet in progress
	burst_t burst_q;                     // burst being sent
	burst_t tx_src;
	logic [WORD_IDX_W-1:0] word_idx;     // word within header or burst
	burst_count_t burst_idx;             // burst within the fill
	logic tx_fire;
	logic last_word;
	logic last_burst;
	logic no_bursts;

	assign tx_fire = tx_valid && tx_ready;
	assign last_word = (word_idx == WORD_IDX_W'(WORDS_PER_BURST - 1));
	assign last_burst = (burst_idx == hdr_q.burst_count - 1'b1);
	assign no_bursts = (hdr_q.burst_count == '0); // header only packet

	////////////////////////////////////////////////////////////
	// header pop and memory read client
	assign hdr_pop = (state == RD_IDLE) && !hdr_empty && !readout_pause;
	assign rd_req = (state == RD_REQ);
	assign rd_addr = hdr_q.start_addr[MEM_ADDR_W-1:0] + burst_idx[MEM_ADDR_W-1:0]; // wraps

	always_ff @(posedge clk) begin
		if (hdr_pop) hdr_q <= hdr_data;
	end

	always_ff @(posedge clk) begin
		if (rd_req && rd_ack) burst_q <= rd_burst;  // latched, so req drops at once
	end

	////////////////////////////////////////////////////////////
	// packet sequencing
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= RD_IDLE;
			word_idx <= '0;
			burst_idx <= '0;
		end else begin
			case (state)
				RD_IDLE: if (hdr_pop) begin
					word_idx <= '0;
					burst_idx <= '0;
					state <= RD_HDR;
				end
				RD_HDR: if (tx_fire) begin
					word_idx <= word_idx + 1'b1;     // wraps to 0 after the last word
					if (last_word) state <= no_bursts ? RD_IDLE : RD_REQ;
				end
				// burst send outlasts the ack fall, so req never rises early
				RD_REQ: if (rd_ack) state <= RD_BURST;
				RD_BURST: if (tx_fire) begin
					word_idx <= word_idx + 1'b1;
					if (last_word) begin
						burst_idx <= burst_idx + 1'b1;
						state <= last_burst ? RD_IDLE : RD_REQ;
					end
				end
				default: state <= RD_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// stream out, msw first
	assign tx_valid = (state == RD_HDR) || (state == RD_BURST);
	assign tx_src = (state == RD_HDR) ? burst_t'(hdr_q) : burst_q;
	assign tx_data = tx_src[(WORD_IDX_W'(WORDS_PER_BURST - 1) - word_idx)*WORD_W +: WORD_W];
	assign tx_last = last_word && (((state == RD_HDR) && no_bursts) ||
		((state == RD_BURST) && last_burst));

endmodule

/* hdl/sync_fifo.sv */
`timescale 1ns/1ns

module sync_fifo #(
	parameter type payload_t = logic [31:0],
	parameter int DEPTH = 4
) (
	input  logic clk,
	input  logic reset,
	input  logic push,         // write push_data when not full
	input  payload_t push_data,
	input  logic pop,          // drop the head entry when not empty
	output payload_t pop_data, // head entry, always shown
	output logic empty,
	output logic full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];      // circular buffer
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;    // occupancy
	logic do_push;
	logic do_pop;

	// pointer step with wrap at DEPTH, depth need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign do_push = push && !full;   // push into a full fifo is lost
	assign do_pop = pop && !empty;
	assign empty = (count == '0);
	assign full = (count == CNT_W'(DEPTH));
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) wr_ptr <= ptr_next(wr_ptr);
			if (do_pop) rd_ptr <= ptr_next(rd_ptr);
			if (do_push && !do_pop) count <= count + 1'b1;
			else if (do_pop && !do_push) count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) mem[wr_ptr] <= push_data; // storage only
	end

endmodule

/* hdl/wfd_pkg.sv */
package wfd_pkg;

	////////////////////////////////////////////////////////////
	// widths
	localparam int SAMPLE_W = 12;                      // adc sample
	localparam int SLOT_W = 16;                        // one sample slot in a burst
	localparam int SAMPLES_PER_BURST = 8;              // slots per 128-bit burst
	localparam int BURST_W = SAMPLES_PER_BURST * SLOT_W;
	localparam int WORD_W = 32;                        // stream word
	localparam int WORDS_PER_BURST = BURST_W / WORD_W; // 4, header is the same size
	localparam int FILL_NUM_W = 24;
	localparam int BURST_COUNT_W = 21;
	localparam int CHANNEL_TAG_W = 16;
	localparam int HDR_ADDR_W = 8;                     // start_addr field in the header

	////////////////////////////////////////////////////////////
	// data types
	typedef logic [SAMPLE_W-1:0] sample_t;           // one adc sample
	typedef logic [BURST_W-1:0] burst_t;             // slot 0 in the low bits
	typedef logic [WORD_W-1:0] word_t;               // one output word
	typedef logic [FILL_NUM_W-1:0] fill_num_t;
	typedef logic [BURST_COUNT_W-1:0] burst_count_t;
	typedef logic [CHANNEL_TAG_W-1:0] channel_tag_t;

	// fill type, same code as the two acq_enable bits
	typedef enum logic [1:0] {
		FILL_NONE = 2'd0,     // acquisition disabled
		FILL_MUON = 2'd1,
		FILL_LASER = 2'd2,
		FILL_PEDESTAL = 2'd3
	} fill_type_e;

	////////////////////////////////////////////////////////////
	// fill header, msb first
	typedef struct packed {
		fill_num_t fill_num;               // [127:104]
		fill_type_e fill_type;             // [103:102]
		channel_tag_t channel_tag;         // [101:86]
		burst_count_t burst_count;         // [85:65]
		logic [HDR_ADDR_W-1:0] start_addr; // [64:57] first burst address, zero padded
		logic overrun;                     // [56] at least one burst dropped
		logic [55:0] reserved;             // always zero
	} fill_header_t;

endpackage
